//--- Makefile
# Verilator build and run of the stimulus generator testbench

VERILATOR ?= verilator
TOP       ?= tb_stim_top
FILELIST  ?= stim_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- stim_cfg.svh
// --------------------
// Stimulus generator configuration
// Lane count, data widths, seed base and register map offsets
// --------------------

`ifndef STIM_CFG_SVH
`define STIM_CFG_SVH

// Lanes and data path
`define STIM_NUM_LANES   4
`define STIM_WORD_W      64

// Register bus
`define STIM_ADDR_W      12
`define STIM_DATA_W      32

// Low half of lane 0 seed
`define STIM_SEED_BASE   32'h5678_9F00

// Byte offsets
`define STIM_REG_CTRL    12'h000
`define STIM_REG_ITER    12'h004
`define STIM_REG_STATUS  12'h008
`define STIM_REG_ELAPSED 12'h00C

`endif

//--- stim_ctrl.sv
// --------------------
// Run controller
// Enable edge detect, start pulse, done collection, cycle counter
// --------------------

`include "stim_cfg.svh"
`timescale 1ns/10ps

module stim_ctrl (
  input  logic                 reg_clk,
  input  logic                 rst_n,
  input  stim_pkg::run_cfg_t   cfg,
  input  stim_pkg::lane_mask_t lane_done,
  output logic                 start,
  output stim_pkg::run_stat_t  stat
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FIN
  } state_t;

  state_t                  state;
  logic                    en_q;
  logic                    en_rise;
  logic [`STIM_DATA_W-1:0] elapsed;

  assign en_rise = cfg.test_en & ~en_q;

  always_ff @(posedge reg_clk)
  begin
    if (!rst_n)
    begin
      en_q    <= 1'b0;
      start   <= 1'b0;
      state   <= ST_IDLE;
      elapsed <= '0;
    end
    else
    begin
      en_q  <= cfg.test_en;
      start <= en_rise;
      if (!cfg.test_en)
      begin
        state   <= ST_IDLE;
        elapsed <= '0;
      end
      else
      begin
        case (state)
          ST_IDLE:
          begin
            if (en_rise)
            begin
              state   <= ST_RUN;
              elapsed <= '0;
            end
          end
          ST_RUN:
          begin
            // Finishing edge is counted as well
            elapsed <= elapsed + 1'b1;
            if (&lane_done)
            begin
              state <= ST_FIN;
            end
          end
          // Held until test_en clears
          default:
          begin
          end
        endcase
      end
    end
  end

  assign stat = '{running: (state == ST_RUN), done: (state == ST_FIN), elapsed: elapsed};

endmodule

//--- stim_lane_gen.sv
// --------------------
// One data lane
// Seeded counting pattern, throttled by almost-full
// --------------------

`include "stim_cfg.svh"
`timescale 1ns/10ps

module stim_lane_gen #(
  parameter int LANE = 0
) (
  input  logic                 reg_clk,
  input  logic                 rst_n,
  input  stim_pkg::run_cfg_t   cfg,
  input  logic                 start,
  input  logic                 lane_af,
  output stim_pkg::lane_beat_t beat,
  output logic                 lane_done
);

  localparam int HALF_W = `STIM_WORD_W / 2;

  // Even/odd pair of seeds per lane
  localparam logic [HALF_W-1:0] SEED_LO = HALF_W'(`STIM_SEED_BASE + 2 * LANE);
  localparam logic [HALF_W-1:0] SEED_HI = HALF_W'(SEED_LO + 1);

  logic                    active;
  logic                    done_q;
  logic                    we_q;
  logic [`STIM_WORD_W-1:0] wd_q;
  logic [HALF_W-1:0]       idx;
  logic [`STIM_DATA_W-1:0] remaining;
  logic                    emit;

  assign emit = active & (remaining != '0) & ~lane_af;

  always_ff @(posedge reg_clk)
  begin
    if (!rst_n || !cfg.test_en)
    begin
      active    <= 1'b0;
      done_q    <= 1'b0;
      we_q      <= 1'b0;
      idx       <= '0;
      remaining <= '0;
    end
    else if (start)
    begin
      active    <= 1'b1;
      done_q    <= 1'b0;
      we_q      <= 1'b0;
      idx       <= '0;
      remaining <= cfg.iter_count;
    end
    else
    begin
      we_q <= emit;
      if (emit)
      begin
        idx       <= idx + 1'b1;
        remaining <= remaining - 1'b1;
      end
      // Count exhausted, flag done one edge later
      if (active && remaining == '0)
      begin
        active <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge reg_clk)
  begin
    if (emit)
    begin
      wd_q <= {SEED_HI + idx, SEED_LO + idx};
    end
  end

  assign beat      = '{we: we_q, wd: wd_q};
  assign lane_done = done_q;

endmodule

//--- stim_pkg.sv
// --------------------
// Shared struct types for the register bus,
// lane outputs and run configuration/status
// --------------------

`include "stim_cfg.svh"

package stim_pkg;

  // Strobe bus request, at most one of wr/rd per cycle
  typedef struct packed {
    logic                    wr;
    logic                    rd;
    logic [`STIM_ADDR_W-1:0] addr;
    logic [`STIM_DATA_W-1:0] wdata;
  } reg_req_t;

  // Read data, one cycle after rd
  typedef struct packed {
    logic                    rvalid;
    logic [`STIM_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // One lane word toward the sink
  typedef struct packed {
    logic                    we;
    logic [`STIM_WORD_W-1:0] wd;
  } lane_beat_t;

  typedef struct packed {
    logic                    test_en;
    logic [`STIM_DATA_W-1:0] iter_count;
  } run_cfg_t;

  typedef struct packed {
    logic                    running;
    logic                    done;
    logic [`STIM_DATA_W-1:0] elapsed;
  } run_stat_t;

  // One bit per lane
  typedef logic [`STIM_NUM_LANES-1:0] lane_mask_t;

endpackage

//--- stim_regs.sv
// --------------------
// Register block on the strobe bus
// CTRL and ITER are read/write, STATUS and ELAPSED read-only
// --------------------

`include "stim_cfg.svh"
`timescale 1ns/10ps

module stim_regs (
  input  logic                reg_clk,
  input  logic                rst_n,
  input  stim_pkg::reg_req_t  reg_req,
  input  stim_pkg::run_stat_t stat,
  output stim_pkg::reg_rsp_t  reg_rsp,
  output stim_pkg::run_cfg_t  cfg
);

  logic                    test_en;
  logic [`STIM_DATA_W-1:0] iter_count;
  logic [`STIM_DATA_W-1:0] rd_mux;
  logic                    rvalid_q;
  logic [`STIM_DATA_W-1:0] rdata_q;

  // --------------------
  // Write side
  // --------------------
  always_ff @(posedge reg_clk)
  begin
    if (!rst_n)
    begin
      test_en    <= 1'b0;
      iter_count <= '0;
    end
    else if (reg_req.wr)
    begin
      case (reg_req.addr)
        `STIM_REG_CTRL:
        begin
          test_en <= reg_req.wdata[0];
        end
        `STIM_REG_ITER:
        begin
          iter_count <= reg_req.wdata;
        end
        // Status, elapsed and holes take no writes
        default:
        begin
        end
      endcase
    end
  end

  // --------------------
  // Read side
  // --------------------
  always_comb
  begin
    rd_mux = '0;
    case (reg_req.addr)
      `STIM_REG_CTRL:    rd_mux[0]   = test_en;
      `STIM_REG_ITER:    rd_mux      = iter_count;
      `STIM_REG_STATUS:  rd_mux[1:0] = {stat.done, stat.running};
      `STIM_REG_ELAPSED: rd_mux      = stat.elapsed;
      default:           rd_mux      = '0;
    endcase
  end

  always_ff @(posedge reg_clk)
  begin
    if (!rst_n)
    begin
      rvalid_q <= 1'b0;
    end
    else
    begin
      rvalid_q <= reg_req.rd;
    end
  end

  // Response data held between reads
  always_ff @(posedge reg_clk)
  begin
    if (reg_req.rd)
    begin
      rdata_q <= rd_mux;
    end
  end

  assign reg_rsp = '{rvalid: rvalid_q, rdata: rdata_q};
  assign cfg     = '{test_en: test_en, iter_count: iter_count};

endmodule

//--- stim_top.f
+incdir+.
stim_pkg.sv
stim_regs.sv
stim_ctrl.sv
stim_lane_gen.sv
stim_top.sv
tb_stim_top.sv

//--- stim_top.sv
// --------------------
// Stimulus generator top level
// Register block, run controller and the lane array
// --------------------

`include "stim_cfg.svh"
`timescale 1ns/10ps

module stim_top (
  input  logic                                       reg_clk,
  input  logic                                       rst_n,
  input  stim_pkg::reg_req_t                         reg_req,
  input  stim_pkg::lane_mask_t                       lane_af,
  output stim_pkg::reg_rsp_t                         reg_rsp,
  output stim_pkg::lane_beat_t [`STIM_NUM_LANES-1:0] lane_out
);

  stim_pkg::run_cfg_t   cfg;
  stim_pkg::run_stat_t  stat;
  stim_pkg::lane_mask_t lane_done;
  logic                 start;

  // --------------------
  // Control path
  // --------------------
  stim_regs u_regs (
    .reg_clk (reg_clk),
    .rst_n   (rst_n),
    .reg_req (reg_req),
    .stat    (stat),
    .reg_rsp (reg_rsp),
    .cfg     (cfg)
  );

  stim_ctrl u_ctrl (
    .reg_clk   (reg_clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .lane_done (lane_done),
    .start     (start),
    .stat      (stat)
  );

  // --------------------
  // Data lanes
  // --------------------
  for (genvar l = 0; l < `STIM_NUM_LANES; l++)
  begin : g_lane
    stim_lane_gen #(
      .LANE (l)
    ) u_lane (
      .reg_clk   (reg_clk),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .start     (start),
      .lane_af   (lane_af[l]),
      .beat      (lane_out[l]),
      .lane_done (lane_done[l])
    );
  end

endmodule

//--- tb_stim_top.sv
// --------------------
// Testbench for the stimulus generator
// Bus tasks, almost-full driver, lane word checker, run table
// --------------------

`include "stim_cfg.svh"
`timescale 1ns/10ps

module tb_stim_top;

  localparam int NL          = `STIM_NUM_LANES;
  localparam int NUM_RUNS    = 4;
  localparam int RD_TIMEOUT  = 8;
  localparam int RUN_TIMEOUT = 300;
  localparam int HOLD_EDGES  = 10;

  localparam logic [1:0] AF_NONE = 2'd0;
  localparam logic [1:0] AF_RAND = 2'd1;
  localparam logic [1:0] AF_HOLD = 2'd2;

  typedef struct packed {
    logic [31:0] iter_count;
    logic [1:0]  mode;
    logic [31:0] min_elapsed;
  } run_entry_t;

  logic                          reg_clk;
  logic                          rst_n;
  stim_pkg::reg_req_t            reg_req;
  stim_pkg::lane_mask_t          lane_af;
  stim_pkg::reg_rsp_t            reg_rsp;
  stim_pkg::lane_beat_t [NL-1:0] lane_out;

  run_entry_t    run_table [NUM_RUNS];
  integer        seed;
  logic [1:0]    af_mode;
  int            hold_cnt;
  int            exp_words;
  int            word_cnt [NL];
  int            stall_cnt [NL];
  logic [NL-1:0] af_seen;
  int            errors;
  int            tests_run;
  int            tests_failed;

  stim_top uut (
    .reg_clk  (reg_clk),
    .rst_n    (rst_n),
    .reg_req  (reg_req),
    .lane_af  (lane_af),
    .reg_rsp  (reg_rsp),
    .lane_out (lane_out)
  );

  initial
  begin
    reg_clk = 1'b0;
  end

  always #50 reg_clk = ~reg_clk;

  // Word k of lane L, halves wrap at 32 bits
  function automatic logic [63:0] lane_word(input int lane, input int k);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = `STIM_SEED_BASE + 2 * lane + k;
    hi = lo + 32'd1;
    return {hi, lo};
  endfunction

  // --------------------
  // Almost-full driver
  // --------------------
  always @(posedge reg_clk)
  begin
    if (af_mode == AF_RAND)
    begin
      lane_af  <= stim_pkg::lane_mask_t'($random(seed));
      hold_cnt <= 0;
    end
    else if (af_mode == AF_HOLD && hold_cnt < HOLD_EDGES)
    begin
      // Lane 0 only
      lane_af  <= stim_pkg::lane_mask_t'(1);
      hold_cnt <= hold_cnt + 1;
    end
    else
    begin
      lane_af <= '0;
      if (af_mode != AF_HOLD)
      begin
        hold_cnt <= 0;
      end
    end
  end

  // --------------------
  // Lane word checker
  // --------------------
  // af_seen holds the almost-full value that the last edge sampled
  always @(negedge reg_clk)
  begin
    for (int l = 0; l < NL; l++)
    begin
      if (lane_out[l].we)
      begin
        assert (!af_seen[l])
        else
        begin
          $display("MISMATCH at %0t: lane %0d wrote while almost-full was high", $time, l);
          errors++;
        end
        assert (word_cnt[l] < exp_words)
        else
        begin
          $display("Lane %0d emitted more than %0d words", l, exp_words);
          errors++;
        end
        assert (lane_out[l].wd == lane_word(l, word_cnt[l]))
        else
        begin
          $display("MISMATCH at %0t: lane %0d word %0d is 0x%016h, expected 0x%016h",
                   $time, l, word_cnt[l], lane_out[l].wd, lane_word(l, word_cnt[l]));
          errors++;
        end
        word_cnt[l]++;
      end
      else if (af_seen[l] && word_cnt[l] > 0 && word_cnt[l] < exp_words)
      begin
        stall_cnt[l]++;
      end
    end
    af_seen = lane_af;
  end

  task automatic timeout_abort(input string what);
    $display("Timeout: %s", what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
    stim_pkg::reg_req_t req;
    req       = '0;
    req.wr    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(posedge reg_clk);
    reg_req <= req;
    @(posedge reg_clk);
    reg_req <= '0;
  endtask

  task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
    stim_pkg::reg_req_t req;
    int                 wait_cnt;
    req      = '0;
    req.rd   = 1'b1;
    req.addr = addr;
    wait_cnt = 0;
    @(posedge reg_clk);
    reg_req <= req;
    @(negedge reg_clk);
    assert (!reg_rsp.rvalid)
    else
    begin
      $display("MISMATCH at %0t: rvalid high before the read was sampled", $time);
      errors++;
    end
    @(posedge reg_clk);
    reg_req <= '0;
    @(negedge reg_clk);
    while (!reg_rsp.rvalid)
    begin
      wait_cnt++;
      if (wait_cnt > RD_TIMEOUT)
      begin
        timeout_abort("no read response on the register bus");
      end
      @(negedge reg_clk);
    end
    assert (wait_cnt == 0)
    else
    begin
      $display("Read response came %0d cycles late", wait_cnt);
      errors++;
    end
    data = reg_rsp.rdata;
  endtask

  task automatic check_reg(input string what, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    bus_read(addr, got);
    assert (got == exp)
    else
    begin
      $display("MISMATCH at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic arm_run(input int words, input logic [1:0] mode);
    @(posedge reg_clk);
    af_mode  <= mode;
    exp_words = words;
    for (int l = 0; l < NL; l++)
    begin
      word_cnt[l]  = 0;
      stall_cnt[l] = 0;
    end
  endtask

  // One enabled run, left running until the caller clears CTRL
  task automatic execute_run(input run_entry_t entry);
    logic [31:0] status;
    logic [31:0] elapsed;
    int          polls;
    int          max_stall;
    polls     = 0;
    max_stall = 0;
    bus_write(`STIM_REG_ITER, entry.iter_count);
    arm_run(int'(entry.iter_count), entry.mode);
    bus_write(`STIM_REG_CTRL, 32'd1);
    bus_read(`STIM_REG_STATUS, status);
    while (!status[1])
    begin
      polls++;
      if (polls > RUN_TIMEOUT)
      begin
        timeout_abort("run never reported done");
      end
      bus_read(`STIM_REG_STATUS, status);
    end
    check_reg("STATUS at done", `STIM_REG_STATUS, 32'd2);
    bus_read(`STIM_REG_ELAPSED, elapsed);
    @(posedge reg_clk);
    af_mode <= AF_NONE;
    for (int l = 0; l < NL; l++)
    begin
      assert (word_cnt[l] == exp_words)
      else
      begin
        $display("MISMATCH at %0t: lane %0d gave %0d words, expected %0d",
                 $time, l, word_cnt[l], exp_words);
        errors++;
      end
      if (stall_cnt[l] > max_stall)
      begin
        max_stall = stall_cnt[l];
      end
    end
    assert (elapsed >= entry.min_elapsed + 32'(max_stall))
    else
    begin
      $display("MISMATCH at %0t: ELAPSED %0d below bound %0d",
               $time, elapsed, entry.min_elapsed + 32'(max_stall));
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    tests_run++;
    if (errors == mark)
    begin
      $display("test %0d %s: ok", tests_run, name);
    end
    else
    begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - mark);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    int mark;
    seed         = 98411;
    rst_n        = 1'b0;
    reg_req      = '0;
    lane_af      = '0;
    af_mode      = AF_NONE;
    hold_cnt     = 0;
    exp_words    = 0;
    af_seen      = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int l = 0; l < NL; l++)
    begin
      word_cnt[l]  = 0;
      stall_cnt[l] = 0;
    end
    // {iter_count, af mode, minimum elapsed}
    run_table[0] = '{32'd20, AF_NONE, 32'd20};
    run_table[1] = '{32'd0,  AF_NONE, 32'd0};
    run_table[2] = '{32'd37, AF_RAND, 32'd37};
    run_table[3] = '{32'd16, AF_HOLD, 32'd26};
    repeat (8) @(posedge reg_clk);
    rst_n <= 1'b1;

    mark = errors;
    for (int c = 0; c < 4; c++)
    begin
      @(negedge reg_clk);
      for (int l = 0; l < NL; l++)
      begin
        assert (!lane_out[l].we)
        else
        begin
          $display("MISMATCH at %0t: lane %0d shows we after reset", $time, l);
          errors++;
        end
      end
    end
    check_reg("CTRL", `STIM_REG_CTRL, 32'd0);
    check_reg("ITER", `STIM_REG_ITER, 32'd0);
    check_reg("STATUS", `STIM_REG_STATUS, 32'd0);
    check_reg("ELAPSED", `STIM_REG_ELAPSED, 32'd0);
    finish_test("reset values", mark);

    mark = errors;
    arm_run(3, AF_NONE);
    bus_write(`STIM_REG_ITER, 32'd3);
    bus_write(`STIM_REG_CTRL, 32'd1);
    check_reg("CTRL", `STIM_REG_CTRL, 32'd1);
    check_reg("ITER", `STIM_REG_ITER, 32'd3);
    check_reg("unmapped 0x010", 12'h010, 32'd0);
    check_reg("unmapped 0x0FC", 12'h0FC, 32'd0);
    repeat (10) @(posedge reg_clk);
    bus_write(`STIM_REG_STATUS, 32'hFFFF_FFFE);
    check_reg("STATUS after write", `STIM_REG_STATUS, 32'd2);
    check_reg("ITER after STATUS write", `STIM_REG_ITER, 32'd3);
    bus_write(`STIM_REG_CTRL, 32'd0);
    check_reg("CTRL cleared", `STIM_REG_CTRL, 32'd0);
    finish_test("register readback", mark);

    for (int t = 0; t < NUM_RUNS; t++)
    begin
      mark = errors;
      execute_run(run_table[t]);
      bus_write(`STIM_REG_CTRL, 32'd0);
      finish_test($sformatf("run %0d words mode %0d", run_table[t].iter_count,
                            run_table[t].mode), mark);
    end

    mark = errors;
    execute_run(run_entry_t'{32'd12, AF_NONE, 32'd12});
    bus_write(`STIM_REG_CTRL, 32'd0);
    check_reg("STATUS after clear", `STIM_REG_STATUS, 32'd0);
    check_reg("ELAPSED after clear", `STIM_REG_ELAPSED, 32'd0);
    execute_run(run_entry_t'{32'd7, AF_NONE, 32'd7});
    bus_write(`STIM_REG_CTRL, 32'd0);
    finish_test("restart", mark);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
